// File: hw/spi_bridge_cfg.svh
`ifndef SPI_BRIDGE_CFG_SVH
`define SPI_BRIDGE_CFG_SVH

// Frame opcodes, first byte after chip select falls
`define SB_OP_WRITE 8'h02
`define SB_OP_READ  8'h03

// Flops per bus pin before edge detection
`define SB_SYNC_STAGES 2

`define SB_MEM_DEPTH 256  // Register memory size in bytes

`endif

// File: hw/spi_bridge_pkg.sv
// Types shared by the SPI register bridge blocks
package spi_bridge_pkg;

    typedef logic [7:0] byte_t;  // One SPI or memory data byte
    typedef logic [7:0] addr_t;  // Register memory address

    // Bus inputs as seen after the synchronizer
    typedef struct packed {
        logic cs_n;  // Chip select, active low
        logic sck;   // Serial clock
        logic sd;    // Serial data from controller
    } spi_pins_t;

    // One memory request from the decoder
    typedef struct packed {
        logic  we;     // High for a write
        addr_t addr;
        byte_t wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        ST_OPCODE,  // Waiting for first byte
        ST_ADDR,    // Waiting for start address
        ST_DATA,    // Data bytes
        ST_IGNORE   // Unknown opcode, rest of frame dropped
    } cmd_state_e;

endpackage

// File: hw/spi_shift.sv
`timescale 1ns/100ps

`include "spi_bridge_cfg.svh"

// SPI Mode 0 byte shifter running on the system clock
// SCK and SDI are oversampled and acted on at detected edges
module spi_shift
    import spi_bridge_pkg::*;
(
    input  logic      spi_cs_ni,  // System clock
    input  logic      spi_sck_i,  // Async active low reset
    input  spi_pins_t pins_i,     // Raw bus pins
    input  byte_t     tx_byte_i,  // Byte to send next
    output byte_t     rx_byte_o,  // Last complete byte received
    output logic      strobe_o,   // One clock pulse with rx_byte_o
    output logic      frame_o,    // Synchronized chip select active
    output logic      sd_o        // Serial data to controller
);
    localparam spi_pins_t PINS_IDLE = '{cs_n: 1'b1, sck: 1'b0, sd: 1'b0};

    spi_pins_t  sync_q [`SB_SYNC_STAGES];  // Synchronizer chain
    spi_pins_t  pins_s;                    // Output of last stage
    logic       sck_q;        // Previous synced SCK
    logic       sd_q;         // SDI aligned with edge flags
    logic       rise_q;       // Detected SCK rise
    logic       fall_q;       // Detected SCK fall
    logic       sck_edge;     // Either SCK edge detected
    logic       frame_d;
    logic       frame_q;
    logic       frame_start;  // Chip select just went low
    logic [2:0] bit_cnt_q;    // Bits received in current byte
    byte_t      rx_shift_q;
    byte_t      rx_next;
    byte_t      tx_shift_q;   // Remaining bits to send

    assign pins_s      = sync_q[`SB_SYNC_STAGES-1];
    assign frame_d     = ~pins_s.cs_n;
    assign frame_start = frame_d & ~frame_q;
    assign rx_next     = {rx_shift_q[6:0], sd_q};  // MSB first
    assign frame_o     = frame_q;
    assign sck_edge    = rise_q | fall_q;

    // Pin synchronizer
    always_ff @(posedge spi_cs_ni or negedge spi_sck_i) begin
        if (!spi_sck_i) begin
            for (int i = 0; i < `SB_SYNC_STAGES; i++) begin
                sync_q[i] <= PINS_IDLE;
            end
        end else begin
            sync_q[0] <= pins_i;
            for (int i = 1; i < `SB_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // Edge detection one clock behind the synchronizer
    always_ff @(posedge spi_cs_ni or negedge spi_sck_i) begin
        if (!spi_sck_i) begin
            sck_q   <= 1'b0;
            sd_q    <= 1'b0;
            rise_q  <= 1'b0;
            fall_q  <= 1'b0;
            frame_q <= 1'b0;
        end else begin
            sck_q   <= pins_s.sck;
            sd_q    <= pins_s.sd;               // Stable around the rise
            rise_q  <= pins_s.sck & ~sck_q;
            fall_q  <= ~pins_s.sck & sck_q;
            frame_q <= frame_d;
        end
    end

    // Bit counter and byte strobe
    always_ff @(posedge spi_cs_ni or negedge spi_sck_i) begin
        if (!spi_sck_i) begin
            bit_cnt_q <= '0;
            strobe_o  <= 1'b0;
        end else if (!frame_q) begin
            bit_cnt_q <= '0;                    // CS high drops a partial byte
            strobe_o  <= 1'b0;
        end else begin
            strobe_o <= rise_q & frame_d & (bit_cnt_q == 3'd7);  // LSB just in
            if (rise_q) begin
                bit_cnt_q <= bit_cnt_q + 3'd1;  // Wraps to 0 after the LSB
            end
        end
    end

    // Receive shift register
    always_ff @(posedge spi_cs_ni) begin
        if (frame_q && rise_q) begin
            rx_shift_q <= rx_next;
            if (bit_cnt_q == 3'd7) begin
                rx_byte_o <= rx_next;
            end
        end
    end

    // Transmit side shifts SDO after each SCK fall
    always_ff @(posedge spi_cs_ni or negedge spi_sck_i) begin
        if (!spi_sck_i) begin
            tx_shift_q <= '0;
            sd_o       <= 1'b0;
        end else if (frame_start) begin
            sd_o       <= tx_byte_i[7];            // MSB before first rise
            tx_shift_q <= {tx_byte_i[6:0], 1'b0};
        end else if (!frame_q) begin
            sd_o <= 1'b0;
        end else if (fall_q) begin
            if (bit_cnt_q == 3'd0) begin
                // Fall after a strobe starts the next byte
                sd_o       <= tx_byte_i[7];
                tx_shift_q <= {tx_byte_i[6:0], 1'b0};
            end else begin
                sd_o       <= tx_shift_q[7];
                tx_shift_q <= {tx_shift_q[6:0], 1'b0};
            end
        end
    end

    // Each SCK half period lasts at least six clocks
    assert property (@(posedge spi_cs_ni) disable iff (!spi_sck_i)
        sck_edge |-> !($past(sck_edge, 1) || $past(sck_edge, 2) || $past(sck_edge, 3)
                       || $past(sck_edge, 4) || $past(sck_edge, 5)));

endmodule

// File: hw/spi_cmd_fsm.sv
`timescale 1ns/100ps

`include "spi_bridge_cfg.svh"

// Frame decoder for the opcode, start address and data bytes
module spi_cmd_fsm
    import spi_bridge_pkg::*;
(
    input  logic     spi_cs_ni,  // System clock
    input  logic     spi_sck_i,  // Async active low reset
    input  byte_t    rx_byte_i,  // Byte from shifter
    input  logic     strobe_i,   // rx_byte_i valid
    input  logic     frame_i,    // Chip select active
    output mem_req_t mem_req_o,  // Request to register memory
    input  byte_t    rdata_i,    // Read data one clock after request
    output byte_t    tx_byte_o   // Next byte for the shifter
);
    cmd_state_e state_q;
    addr_t      addr_q;     // Address of next data byte
    logic       wr_mode_q;  // Current frame is a write

    // Memory data only in the data phase of a read frame
    // Opcode and address bytes go out as zero
    assign tx_byte_o = (state_q == ST_DATA && !wr_mode_q) ? rdata_i : 8'h00;

    always_ff @(posedge spi_cs_ni or negedge spi_sck_i) begin
        if (!spi_sck_i) begin
            state_q   <= ST_OPCODE;
            addr_q    <= '0;
            wr_mode_q <= 1'b0;
            mem_req_o <= '0;
        end else begin
            mem_req_o.we <= 1'b0;  // Write is a one clock pulse
            if (!frame_i) begin
                state_q <= ST_OPCODE;  // CS high ends or aborts frame
            end else if (strobe_i) begin
                unique case (state_q)
                    ST_OPCODE: begin
                        if (rx_byte_i == `SB_OP_WRITE) begin
                            wr_mode_q <= 1'b1;
                            state_q   <= ST_ADDR;
                        end else if (rx_byte_i == `SB_OP_READ) begin
                            wr_mode_q <= 1'b0;
                            state_q   <= ST_ADDR;
                        end else begin
                            state_q <= ST_IGNORE;
                        end
                    end
                    ST_ADDR: begin
                        state_q <= ST_DATA;
                        if (wr_mode_q) begin
                            addr_q <= rx_byte_i;
                        end else begin
                            // Prefetch first read byte
                            mem_req_o.addr <= rx_byte_i;
                            addr_q         <= rx_byte_i + 8'd1;
                        end
                    end
                    ST_DATA: begin
                        mem_req_o.addr <= addr_q;
                        addr_q         <= addr_q + 8'd1;  // Wraps 255 to 0
                        if (wr_mode_q) begin
                            mem_req_o.we    <= 1'b1;
                            mem_req_o.wdata <= rx_byte_i;
                        end
                        // For reads the new address fetches the following byte
                    end
                    ST_IGNORE: begin
                        state_q <= ST_IGNORE;  // Until CS rises
                    end
                endcase
            end
        end
    end

    // Strobes come far enough apart for the two clock read prefetch
    assert property (@(posedge spi_cs_ni) disable iff (!spi_sck_i)
        strobe_i |-> !($past(strobe_i, 1) || $past(strobe_i, 2)));

endmodule

// File: hw/reg_ram.sv
`timescale 1ns/100ps

`include "spi_bridge_cfg.svh"

// Register memory, one port
// Synchronous write, registered read
module reg_ram
    import spi_bridge_pkg::*;
(
    input  logic     spi_cs_ni,  // System clock
    input  mem_req_t mem_req_i,  // Write enable, address, write data
    output byte_t    rdata_o     // Read data, one clock after address
);
    byte_t mem_q [`SB_MEM_DEPTH];

    // A read happens on every clock without a write
    // Read data holds while the decoder holds the address
    always_ff @(posedge spi_cs_ni) begin
        if (mem_req_i.we) begin
            mem_q[mem_req_i.addr] <= mem_req_i.wdata;  // Lands on the request edge
        end else begin
            rdata_o <= mem_q[mem_req_i.addr];
        end
    end

endmodule

// File: hw/spi_bridge_top.sv
`timescale 1ns/100ps

// SPI Mode 0 peripheral with a 256 byte register memory
module spi_bridge_top
    import spi_bridge_pkg::*;
(
    input  logic spi_cs_ni,  // System clock
    input  logic spi_sck_i,  // Async reset, active low
    input  logic bus_cs_ni,  // SPI chip select
    input  logic bus_sck_i,  // SPI clock
    input  logic bus_sd_i,   // SPI data in
    output logic bus_sd_o    // SPI data out
);
    spi_pins_t pins;       // Raw bus pins
    byte_t     rx_byte;
    logic      strobe;
    logic      frame;
    byte_t     tx_byte;
    mem_req_t  mem_req;
    byte_t     rdata;

    assign pins = '{cs_n: bus_cs_ni, sck: bus_sck_i, sd: bus_sd_i};

    spi_shift shift0 (
        .spi_cs_ni (spi_cs_ni),
        .spi_sck_i (spi_sck_i),
        .pins_i    (pins),
        .tx_byte_i (tx_byte),
        .rx_byte_o (rx_byte),
        .strobe_o  (strobe),
        .frame_o   (frame),
        .sd_o      (bus_sd_o)
    );

    spi_cmd_fsm cmd0 (
        .spi_cs_ni (spi_cs_ni),
        .spi_sck_i (spi_sck_i),
        .rx_byte_i (rx_byte),
        .strobe_i  (strobe),
        .frame_i   (frame),
        .mem_req_o (mem_req),
        .rdata_i   (rdata),
        .tx_byte_o (tx_byte)
    );

    reg_ram ram0 (
        .spi_cs_ni (spi_cs_ni),
        .mem_req_i (mem_req),
        .rdata_o   (rdata)
    );

endmodule

// File: bench/spi_bridge_tb.sv
`timescale 1ns/100ps

`include "spi_bridge_cfg.svh"

// Testbench for the SPI register bridge
// Mode 0 controller model driven from the stim file and checked against a memory model
module spi_bridge_tb
    import spi_bridge_pkg::*;
();
    localparam int HALF      = 8;     // System clocks per SCK half period
    localparam int MAX_TESTS = 64;
    localparam int MAX_BYTES = 1024;

    logic spi_cs_ni;  // System clock
    logic spi_sck_i;  // Active low reset
    logic bus_cs_ni;
    logic bus_sck_i;
    logic bus_sd_i;
    logic bus_sd_o;

    logic [7:0] kind_a [MAX_TESTS];  // Test kind letter
    byte_t      op_a   [MAX_TESTS];
    addr_t      addr_a [MAX_TESTS];
    int         cnt_a  [MAX_TESTS];  // Data bytes per frame
    int         off_a  [MAX_TESTS];  // First byte in data_a
    byte_t      data_a [MAX_BYTES];
    int         n_tests;
    int         limit_clks;          // Watchdog budget that stays 0 until the stim is read

    byte_t model_mem [`SB_MEM_DEPTH];
    logic  written   [`SB_MEM_DEPTH];  // Location holds a known value
    byte_t tx_q [$];                   // Bytes of the next frame
    byte_t rx_q [$];                   // Bytes seen on bus_sd_o
    int    err_cnt;
    int    pass_cnt;
    int    fail_cnt;

    always #4 spi_cs_ni = ~spi_cs_ni;

    spi_bridge_top dut0 (
        .spi_cs_ni (spi_cs_ni),
        .spi_sck_i (spi_sck_i),
        .bus_cs_ni (bus_cs_ni),
        .bus_sck_i (bus_sck_i),
        .bus_sd_i  (bus_sd_i),
        .bus_sd_o  (bus_sd_o)
    );

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("FAILED %0t: %s got %02h expected %02h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // One byte or part of one with SCK idling low between bits
    task automatic xfer_byte(input byte_t tx, input int nbits, output byte_t rx);
        byte_t sh;
        sh = tx;
        rx = '0;
        for (int i = 0; i < nbits; i++) begin
            bus_sd_i = sh[7];                // MSB first and set while SCK is low
            sh = {sh[6:0], 1'b0};
            repeat (HALF) @(negedge spi_cs_ni);
            bus_sck_i = 1'b1;
            rx = {rx[6:0], bus_sd_o};        // Sampled at the SCK rise
            repeat (HALF) @(negedge spi_cs_ni);
            bus_sck_i = 1'b0;
        end
    endtask

    // Sends tx_q in one frame with an optional partial byte before CS rises
    task automatic run_frame(input int part_bits, input byte_t part_byte);
        byte_t b;
        rx_q.delete();
        bus_cs_ni = 1'b0;
        foreach (tx_q[i]) begin
            xfer_byte(tx_q[i], 8, b);
            rx_q.push_back(b);
        end
        if (part_bits > 0) begin
            xfer_byte(part_byte, part_bits, b);  // Dropped by the DUT
        end
        repeat (HALF) @(negedge spi_cs_ni);
        bus_cs_ni = 1'b1;
        bus_sd_i  = 1'b0;
        repeat (2 * HALF) @(negedge spi_cs_ni);  // Idle gap between frames
    endtask

    // Data bytes of tx_q land at start, start + 1, ... with 8-bit wrap
    task automatic model_write(input addr_t start, input int n);
        addr_t a;
        a = start;
        for (int i = 0; i < n; i++) begin
            model_mem[a] = tx_q[i + 2];
            written[a]   = 1'b1;
            a = a + 8'd1;
        end
    endtask

    task automatic check_read(input addr_t start, input int n, input int off,
                              input logic from_file);
        addr_t a;
        a = start;
        check_byte("bus_sd_o opcode byte", rx_q[0], 8'h00);  // Idle output
        check_byte("bus_sd_o address byte", rx_q[1], 8'h00);
        for (int i = 0; i < n; i++) begin
            if (from_file) begin
                check_byte($sformatf("bus_sd_o byte %0d", i + 2), rx_q[i + 2], data_a[off + i]);
            end
            if (written[a]) begin
                check_byte($sformatf("bus_sd_o at %02h", a), rx_q[i + 2], model_mem[a]);
            end else begin
                $display("Read of address %02h that no earlier test wrote", a);
                err_cnt++;
            end
            a = a + 8'd1;
        end
    endtask

    // Parses the stim file and sums the frame lengths for the watchdog
    task automatic read_stim(output logic ok);
        int         fd;
        int         c;
        int         r;
        int         nd;
        int         clks;
        int         total;
        int         n_off;
        logic [7:0] kc;
        byte_t      op;
        addr_t      ad;
        int         cnt;
        n_off = 0;
        total = 0;
        n_tests = 0;
        fd = $fopen("bench/spi_bridge_stim.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fscanf(fd, " %c", kc) == 1) begin
                if (kc == "#") begin
                    c = $fgetc(fd);                    // Skip comment line
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else begin
                    r = $fscanf(fd, " %h %h %d", op, ad, cnt);
                    if (r != 3) begin
                        $display("Stim test %0d lacks a valid opcode, address or count",
                                 n_tests);
                        ok = 1'b0;
                    end
                    kind_a[n_tests] = kc;
                    op_a[n_tests]   = op;
                    addr_a[n_tests] = ad;
                    cnt_a[n_tests]  = cnt;
                    off_a[n_tests]  = n_off;
                    nd = (kc == "A") ? cnt + 1 : (kc == "X") ? 0 : cnt;
                    for (int j = 0; j < nd; j++) begin
                        r = $fscanf(fd, " %h", data_a[n_off]);
                        if (r != 1) begin
                            $display("Stim test %0d is short of data bytes", n_tests);
                            ok = 1'b0;
                        end
                        n_off++;
                    end
                    clks = ((2 + cnt) * 8 + ((kc == "A") ? 3 : 0)) * 2 * HALF + 3 * HALF;
                    total += (kc == "X") ? 2 * clks : clks;  // Write plus readback
                    n_tests++;
                end
            end
            $fclose(fd);
            ok = ok && (n_tests > 0);
        end
        limit_clks = 2 * total + 200;  // Margin covers reset and idle
    endtask

    // Watchdog
    initial begin
        wait (limit_clks > 0);
        repeat (limit_clks) @(posedge spi_cs_ni);
        $display("Timeout: the tests did not finish within %0d clocks", limit_clks);
        $display("test failed");
        $finish;
    end

    initial begin
        int          errs_before;
        logic [31:0] rnd;
        addr_t       start;
        logic        ok;
        spi_cs_ni = 1'b0;
        spi_sck_i = 1'b0;  // Reset asserted
        bus_cs_ni = 1'b1;
        bus_sck_i = 1'b0;
        bus_sd_i  = 1'b0;
        err_cnt   = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        limit_clks = 0;
        rnd = $urandom(32'hfd39_0083);  // Seeded once
        for (int i = 0; i < `SB_MEM_DEPTH; i++) begin
            written[i] = 1'b0;
        end
        read_stim(ok);
        repeat (4) @(negedge spi_cs_ni);
        spi_sck_i = 1'b1;
        repeat (4) @(negedge spi_cs_ni);
        if (!ok) begin
            $display("Stim file bench/spi_bridge_stim.txt is missing, malformed or holds no tests");
        end else begin
            for (int t = 0; t < n_tests; t++) begin
                errs_before = err_cnt;
                start = addr_a[t];
                if (kind_a[t] == "X") begin
                    rnd = $urandom;
                    start = rnd[7:0];
                end
                tx_q.delete();
                tx_q.push_back(op_a[t]);
                tx_q.push_back(start);
                case (kind_a[t])
                    "W", "A": begin
                        for (int j = 0; j < cnt_a[t]; j++) begin
                            tx_q.push_back(data_a[off_a[t] + j]);
                        end
                        if (kind_a[t] == "A") begin
                            run_frame(3, data_a[off_a[t] + cnt_a[t]]);
                        end else begin
                            run_frame(0, 8'h00);
                        end
                        if (op_a[t] == `SB_OP_WRITE) begin
                            model_write(start, cnt_a[t]);  // Other opcodes change nothing
                        end
                    end
                    "R": begin
                        for (int j = 0; j < cnt_a[t]; j++) begin
                            tx_q.push_back(8'h00);   // Dummy bytes clock data out
                        end
                        run_frame(0, 8'h00);
                        check_read(start, cnt_a[t], off_a[t], 1'b1);
                    end
                    "X": begin
                        for (int j = 0; j < cnt_a[t]; j++) begin
                            rnd = $urandom;
                            tx_q.push_back(rnd[7:0]);
                        end
                        run_frame(0, 8'h00);
                        model_write(start, cnt_a[t]);
                        tx_q.delete();
                        tx_q.push_back(`SB_OP_READ);
                        tx_q.push_back(start);
                        for (int j = 0; j < cnt_a[t]; j++) begin
                            tx_q.push_back(8'h00);
                        end
                        run_frame(0, 8'h00);
                        check_read(start, cnt_a[t], 0, 1'b0);  // Model gives expected
                    end
                    default: begin
                        $display("Unknown test kind %s in test %0d", kind_a[t], t);
                        err_cnt++;
                    end
                endcase
                if (err_cnt == errs_before) begin
                    pass_cnt++;
                    $display("[%0d] %s op %02h addr %02h count %0d OK",
                             t, kind_a[t], op_a[t], start, cnt_a[t]);
                end else begin
                    fail_cnt++;
                    $display("[%0d] %s op %02h addr %02h count %0d MISMATCH",
                             t, kind_a[t], op_a[t], start, cnt_a[t]);
                end
            end
        end
        $display("Tests %0d, passed %0d, mismatched %0d, errors %0d",
                 n_tests, pass_cnt, fail_cnt, err_cnt);
        if (ok && err_cnt == 0 && fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+hw
hw/spi_bridge_pkg.sv
hw/spi_shift.sv
hw/spi_cmd_fsm.sv
hw/reg_ram.sv
hw/spi_bridge_top.sv
bench/spi_bridge_tb.sv

// File: Makefile
# Verilator build and run of the SPI register bridge testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module spi_bridge_tb -Mdir obj_dir -f list.f
	./obj_dir/Vspi_bridge_tb > sim.log 2>&1; cat sim.log
	@if grep -qx "test passed" sim.log; then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: bench/spi_bridge_stim.txt
# kind opcode address count data..., all hex except the decimal count
# W sends a frame as given, A cuts it after count bytes and 3 bits of one more byte
# R reads and expects the data, X writes count random bytes at a random address, reads back
W 02 40 4 a5 3c 7e 01
R 03 40 4 a5 3c 7e 01
W 02 fe 4 11 22 33 44
R 03 fe 4 11 22 33 44
R 03 ff 3 22 33 44
W 55 40 3 de ad be
R 03 40 4 a5 3c 7e 01
W 55 fe 2 ee ee
R 03 fe 2 11 22
W 02 80 4 c1 c2 c3 c4
A 02 80 2 99 88 77
R 03 80 4 99 88 c3 c4
W 02 10 1 5a
W 02 11 3 01 02 03
R 03 10 4 5a 01 02 03
X 02 00 16
X 02 00 16
